/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= execute_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;
    import trap_pkg::*;

    localparam int LINK_STEP_NORMAL     = 4;
    localparam int LINK_STEP_COMPRESSED = 2;
    localparam int SHAMT_W              = 5;
    localparam int STRB_W               = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // Bits 11:10 both set mean read-only, bits 9:8 give the lowest privilege
    typedef logic [11:0] csr_addr_t;

    // Operation handed over by the decode stage
    typedef enum logic [5:0] {
        NOP, LUI, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET
    } exec_op_e;

    typedef enum logic [3:0] {
        SEL_SUM, SEL_LINK, SEL_LT, SEL_LTU, SEL_XOR,
        SEL_OR, SEL_AND, SEL_SHIFT, SEL_PASS, SEL_CSR
    } alu_sel_e;

    typedef enum logic [1:0] {
        SHIFT_LL,
        SHIFT_RL,
        SHIFT_RA
    } shift_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU, BR_ALWAYS
    } branch_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_e;

    typedef struct packed {
        alu_sel_e     alu_sel;
        shift_e       shift;
        logic         use_link;
        logic         is_sub;
        branch_cond_e branch_cond;
        logic         is_jalr;
        logic         is_load;
        logic         is_store;
        mem_size_e    mem_size;
        csr_op_e      csr_op;
        logic         csr_imm;
        logic         writes_rd;
    } op_ctrl_t;

    typedef struct packed {
        word_t             addr;
        logic              read_en;
        logic [STRB_W-1:0] strobe;
        word_t             wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* common/trap_pkg.sv */
`default_nettype none

package trap_pkg;

    // Privilege levels in mstatus.MPP encoding
    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_level_e;

    // mcause values for synchronous exceptions
    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED   = 5'd0,
        EXC_INSTR_ACCESS_FAULT = 5'd1,
        EXC_ILLEGAL_INSTR      = 5'd2,
        EXC_BREAKPOINT         = 5'd3,
        EXC_LOAD_ACCESS_FAULT  = 5'd5,
        EXC_ECALL_U            = 5'd8,
        EXC_ECALL_M            = 5'd11,
        EXC_NONE               = 5'd31
    } exc_code_e;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    // Faults flagged by fetch and decode
    typedef struct packed {
        logic illegal_instr;
        logic misaligned_fetch;
        logic instr_access_fault;
        logic load_access_fault;
    } exc_flags_t;

    typedef struct packed {
        logic        raise;
        logic        mret;
        logic        irq_ack;
        exc_code_e   exc_code;
        logic [31:0] target;
    } trap_out_t;

endpackage

`default_nettype wire

/* execute/alu_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_unit
    import exec_pkg::*;
(
    input  op_ctrl_t ctrl_i,
    input  word_t    pc_i,
    input  word_t    op_a_i,
    input  word_t    op_b_i,
    input  word_t    op_c_i,
    input  logic     compressed_i,
    output word_t    sum_o,
    output word_t    link_sum_o,
    output word_t    alu_result_o,
    output logic     eq_o,
    output logic     lt_o,
    output logic     ltu_o
);

    logic [SHAMT_W-1:0] shamt;
    word_t              link_step;
    word_t              shift_result;

    assign shamt     = op_b_i[SHAMT_W-1:0];
    assign link_step = compressed_i ? word_t'(LINK_STEP_COMPRESSED)
                                    : word_t'(LINK_STEP_NORMAL);

    // Main adder, also the load/store address and JAL/JALR target
    assign sum_o = op_a_i + op_b_i;

    // Second adder for link address, SUB and branch target
    always_comb begin
        if (ctrl_i.is_sub)
            link_sum_o = op_a_i - op_b_i;
        else if (ctrl_i.use_link)
            link_sum_o = pc_i + link_step;
        else
            link_sum_o = pc_i + op_c_i;
    end

    assign eq_o  = (op_a_i == op_b_i);
    assign lt_o  = ($signed(op_a_i) < $signed(op_b_i));
    assign ltu_o = (op_a_i < op_b_i);

    always_comb begin
        case (ctrl_i.shift)
            SHIFT_LL: shift_result = op_a_i << shamt;
            SHIFT_RL: shift_result = op_a_i >> shamt;
            default:  shift_result = word_t'($signed(op_a_i) >>> shamt);
        endcase
    end

    always_comb begin
        case (ctrl_i.alu_sel)
            SEL_LT:    alu_result_o = word_t'(lt_o);
            SEL_LTU:   alu_result_o = word_t'(ltu_o);
            SEL_XOR:   alu_result_o = op_a_i ^ op_b_i;
            SEL_OR:    alu_result_o = op_a_i | op_b_i;
            SEL_AND:   alu_result_o = op_a_i & op_b_i;
            SEL_SHIFT: alu_result_o = shift_result;
            default:   alu_result_o = sum_o;
        endcase
    end

endmodule

`default_nettype wire

/* execute/branch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module branch_unit
    import exec_pkg::*;
(
    input  op_ctrl_t ctrl_i,
    input  word_t    sum_i,
    input  word_t    link_sum_i,
    input  logic     eq_i,
    input  logic     lt_i,
    input  logic     ltu_i,
    output logic     jump_o,
    output word_t    target_o
);

    always_comb begin
        case (ctrl_i.branch_cond)
            BR_EQ:     jump_o = eq_i;
            BR_NE:     jump_o = !eq_i;
            BR_LT:     jump_o = lt_i;
            BR_LTU:    jump_o = ltu_i;
            BR_GE:     jump_o = !lt_i;
            BR_GEU:    jump_o = !ltu_i;
            BR_ALWAYS: jump_o = 1'b1;
            default:   jump_o = 1'b0;
        endcase
    end

    // JALR drops bit 0, conditional branches use pc plus offset
    always_comb begin
        if (ctrl_i.is_jalr)
            target_o = {sum_i[31:1], 1'b0};
        else if (ctrl_i.branch_cond == BR_ALWAYS)
            target_o = sum_i;
        else
            target_o = link_sum_i;
    end

endmodule

`default_nettype wire

/* execute/csr_access.sv */
`default_nettype none
`timescale 1ns/100ps

module csr_access
    import exec_pkg::*;
    import trap_pkg::*;
(
    input  op_ctrl_t    ctrl_i,
    input  word_t       op_a_i,
    input  reg_addr_t   rs1_i,
    input  reg_addr_t   rd_i,
    input  csr_addr_t   csr_addr_i,
    input  priv_level_e priv_i,
    output logic        read_en_o,
    output logic        write_en_o,
    output csr_op_e     op_o,
    output word_t       data_o,
    output logic        illegal_o
);

    logic read_req;
    logic write_req;
    logic read_only_fail;
    logic priv_fail;

    // CSRRW skips the read for x0, CSRRS/CSRRC skip the write for x0
    always_comb begin
        case (ctrl_i.csr_op)
            CSR_WRITE: begin
                read_req  = (rd_i != '0);
                write_req = 1'b1;
            end
            CSR_SET, CSR_CLEAR: begin
                read_req  = 1'b1;
                write_req = (rs1_i != '0);
            end
            default: begin
                read_req  = 1'b0;
                write_req = 1'b0;
            end
        endcase
    end

    assign read_only_fail = (csr_addr_i[11:10] == 2'b11) && write_req;
    assign priv_fail      = (csr_addr_i[9:8] > priv_i) && (read_req || write_req);
    assign illegal_o      = read_only_fail || priv_fail;

    assign read_en_o  = read_req && !illegal_o;
    assign write_en_o = write_req && !illegal_o;
    assign op_o       = ctrl_i.csr_op;

    // Immediate forms carry the zimm in the rs1 field
    assign data_o = ctrl_i.csr_imm ? word_t'(rs1_i) : op_a_i;

endmodule

`default_nettype wire

/* execute/mem_access.sv */
`default_nettype none
`timescale 1ns/100ps

module mem_access
    import exec_pkg::*;
(
    input  op_ctrl_t ctrl_i,
    input  word_t    sum_i,
    input  word_t    store_data_i,
    output mem_req_t req_o
);

    always_comb begin
        req_o.addr    = {sum_i[31:2], 2'b00};
        req_o.read_en = ctrl_i.is_load;
        req_o.strobe  = '0;
        req_o.wdata   = store_data_i;

        // Lane strobes from the low address bits, data copied to every lane
        if (ctrl_i.is_store) begin
            case (ctrl_i.mem_size)
                MEM_BYTE: begin
                    req_o.strobe = STRB_W'(1) << sum_i[1:0];
                    req_o.wdata  = {4{store_data_i[7:0]}};
                end
                MEM_HALF: begin
                    req_o.strobe = sum_i[1] ? 4'b1100 : 4'b0011;
                    req_o.wdata  = {2{store_data_i[15:0]}};
                end
                default: req_o.strobe = '1;
            endcase
        end
    end

    // Decode never marks one operation as both load and store
    always_comb begin
        if (req_o.read_en)
            assert (req_o.strobe == '0)
                else $error("mem_access: write strobe set on a load");
    end

endmodule

`default_nettype wire

/* execute_stage.f */
common/trap_pkg.sv
common/exec_pkg.sv
hdl/op_decode.sv
execute/alu_unit.sv
execute/branch_unit.sv
execute/mem_access.sv
execute/csr_access.sv
hdl/trap_control.sv
hdl/result_stage.sv
hdl/execute_stage.sv
verif/tb_execute_stage.sv

/* hdl/execute_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module execute_stage
    import exec_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        stall_i,
    input  word_t       pc_i,
    input  word_t       op_a_i,
    input  word_t       op_b_i,
    input  word_t       op_c_i,
    input  exec_op_e    op_i,
    input  reg_addr_t   rd_i,
    input  reg_addr_t   rs1_i,
    input  logic        compressed_i,
    input  priv_level_e priv_i,
    input  exc_flags_t  faults_i,
    input  csr_addr_t   csr_addr_i,
    input  word_t       csr_rdata_i,
    input  logic        irq_pending_i,
    input  word_t       mtvec_i,
    input  word_t       mepc_i,
    output word_t       result_o,
    output logic        we_o,
    output reg_addr_t   rd_o,
    output exec_op_e    op_o,
    output mem_req_t    mem_req_o,
    output logic        csr_read_en_o,
    output logic        csr_write_en_o,
    output csr_op_e     csr_op_o,
    output word_t       csr_data_o,
    output logic        jump_o,
    output trap_out_t   trap_o,
    output logic        ctx_switch_o
);

    op_ctrl_t ctrl;
    word_t    sum;
    word_t    link_sum;
    word_t    alu_result;
    word_t    branch_target;
    logic     eq;
    logic     lt;
    logic     ltu;
    logic     branch_jump;
    logic     csr_illegal;

    //////////////////////////////////////////////////
    // Decode and execution units
    //////////////////////////////////////////////////

    op_decode u_decode (
        .op_i   (op_i),
        .ctrl_o (ctrl)
    );

    alu_unit u_alu (
        .ctrl_i       (ctrl),
        .pc_i         (pc_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .op_c_i       (op_c_i),
        .compressed_i (compressed_i),
        .sum_o        (sum),
        .link_sum_o   (link_sum),
        .alu_result_o (alu_result),
        .eq_o         (eq),
        .lt_o         (lt),
        .ltu_o        (ltu)
    );

    branch_unit u_branch (
        .ctrl_i     (ctrl),
        .sum_i      (sum),
        .link_sum_i (link_sum),
        .eq_i       (eq),
        .lt_i       (lt),
        .ltu_i      (ltu),
        .jump_o     (branch_jump),
        .target_o   (branch_target)
    );

    // Store data arrives on the third operand
    mem_access u_mem (
        .ctrl_i       (ctrl),
        .sum_i        (sum),
        .store_data_i (op_c_i),
        .req_o        (mem_req_o)
    );

    csr_access u_csr (
        .ctrl_i     (ctrl),
        .op_a_i     (op_a_i),
        .rs1_i      (rs1_i),
        .rd_i       (rd_i),
        .csr_addr_i (csr_addr_i),
        .priv_i     (priv_i),
        .read_en_o  (csr_read_en_o),
        .write_en_o (csr_write_en_o),
        .op_o       (csr_op_o),
        .data_o     (csr_data_o),
        .illegal_o  (csr_illegal)
    );

    //////////////////////////////////////////////////
    // Traps and write-back
    //////////////////////////////////////////////////

    trap_control u_trap (
        .ctrl_i        (ctrl),
        .op_i          (op_i),
        .priv_i        (priv_i),
        .faults_i      (faults_i),
        .csr_illegal_i (csr_illegal),
        .jump_i        (branch_jump),
        .target_i      (branch_target),
        .irq_pending_i (irq_pending_i),
        .mtvec_i       (mtvec_i),
        .mepc_i        (mepc_i),
        .trap_o        (trap_o),
        .jump_o        (jump_o),
        .ctx_switch_o  (ctx_switch_o)
    );

    result_stage u_result (
        .clk          (clk),
        .reset_n      (reset_n),
        .stall_i      (stall_i),
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .link_sum_i   (link_sum),
        .csr_rdata_i  (csr_rdata_i),
        .op_b_i       (op_b_i),
        .op_i         (op_i),
        .rd_i         (rd_i),
        .raise_i      (trap_o.raise),
        .result_o     (result_o),
        .we_o         (we_o),
        .rd_o         (rd_o),
        .op_o         (op_o)
    );

endmodule

`default_nettype wire

/* hdl/op_decode.sv */
`default_nettype none
`timescale 1ns/100ps

module op_decode
    import exec_pkg::*;
    import trap_pkg::*;
(
    input  exec_op_e op_i,
    output op_ctrl_t ctrl_o
);

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.writes_rd = !(op_i inside {NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU});
        ctrl_o.is_load   = op_i inside {LB, LBU, LH, LHU, LW};
        ctrl_o.is_store  = op_i inside {SB, SH, SW};
        ctrl_o.is_jalr   = (op_i == JALR);
        ctrl_o.csr_imm   = op_i inside {CSRRWI, CSRRSI, CSRRCI};

        case (op_i)
            LUI:            ctrl_o.alu_sel = SEL_PASS;
            SLT:            ctrl_o.alu_sel = SEL_LT;
            SLTU:           ctrl_o.alu_sel = SEL_LTU;
            XOR:            ctrl_o.alu_sel = SEL_XOR;
            OR:             ctrl_o.alu_sel = SEL_OR;
            AND:            ctrl_o.alu_sel = SEL_AND;
            SLL:            ctrl_o.alu_sel = SEL_SHIFT;
            SRL: begin
                ctrl_o.alu_sel = SEL_SHIFT;
                ctrl_o.shift   = SHIFT_RL;
            end
            SRA: begin
                ctrl_o.alu_sel = SEL_SHIFT;
                ctrl_o.shift   = SHIFT_RA;
            end
            SUB: begin
                ctrl_o.alu_sel = SEL_LINK;
                ctrl_o.is_sub  = 1'b1;
            end
            // Return address goes through the second adder
            JAL, JALR: begin
                ctrl_o.alu_sel     = SEL_LINK;
                ctrl_o.use_link    = 1'b1;
                ctrl_o.branch_cond = BR_ALWAYS;
            end
            SH:             ctrl_o.mem_size = MEM_HALF;
            SW:             ctrl_o.mem_size = MEM_WORD;
            BEQ:            ctrl_o.branch_cond = BR_EQ;
            BNE:            ctrl_o.branch_cond = BR_NE;
            BLT:            ctrl_o.branch_cond = BR_LT;
            BLTU:           ctrl_o.branch_cond = BR_LTU;
            BGE:            ctrl_o.branch_cond = BR_GE;
            BGEU:           ctrl_o.branch_cond = BR_GEU;
            CSRRW, CSRRWI:  ctrl_o.csr_op = CSR_WRITE;
            CSRRS, CSRRSI:  ctrl_o.csr_op = CSR_SET;
            CSRRC, CSRRCI:  ctrl_o.csr_op = CSR_CLEAR;
            default:        ;
        endcase

        // CSR instructions write back the old CSR value
        if (ctrl_o.csr_op != CSR_NONE)
            ctrl_o.alu_sel = SEL_CSR;
    end

endmodule

`default_nettype wire

/* hdl/result_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module result_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall_i,
    input  op_ctrl_t  ctrl_i,
    input  word_t     alu_result_i,
    input  word_t     link_sum_i,
    input  word_t     csr_rdata_i,
    input  word_t     op_b_i,
    input  exec_op_e  op_i,
    input  reg_addr_t rd_i,
    input  logic      raise_i,
    output word_t     result_o,
    output logic      we_o,
    output reg_addr_t rd_o,
    output exec_op_e  op_o
);

    word_t result;
    logic  we;

    always_comb begin
        case (ctrl_i.alu_sel)
            SEL_LINK: result = link_sum_i;
            SEL_PASS: result = op_b_i;
            SEL_CSR:  result = csr_rdata_i;
            default:  result = alu_result_i;
        endcase
    end

    // A trapping instruction must not retire its result
    assign we = ctrl_i.writes_rd && (rd_i != '0) && !raise_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
            we_o     <= 1'b0;
            rd_o     <= '0;
            op_o     <= NOP;
        end else if (stall_i) begin
            // Bubble
            result_o <= '0;
            we_o     <= 1'b0;
            rd_o     <= '0;
            op_o     <= NOP;
        end else begin
            result_o <= result;
            we_o     <= we;
            rd_o     <= rd_i;
            op_o     <= op_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/trap_control.sv */
`default_nettype none
`timescale 1ns/100ps

module trap_control
    import exec_pkg::*;
    import trap_pkg::*;
(
    input  op_ctrl_t    ctrl_i,
    input  exec_op_e    op_i,
    input  priv_level_e priv_i,
    input  exc_flags_t  faults_i,
    input  logic        csr_illegal_i,
    input  logic        jump_i,
    input  word_t       target_i,
    input  logic        irq_pending_i,
    input  word_t       mtvec_i,
    input  word_t       mepc_i,
    output trap_out_t   trap_o,
    output logic        jump_o,
    output logic        ctx_switch_o
);

    logic mem_active;

    assign mem_active = ctrl_i.is_load || ctrl_i.is_store;

    //////////////////////////////////////////////////
    // Cause priority
    //////////////////////////////////////////////////

    always_comb begin
        trap_o.raise    = 1'b1;
        trap_o.mret     = 1'b0;
        trap_o.irq_ack  = 1'b0;
        trap_o.exc_code = EXC_NONE;

        if (faults_i.instr_access_fault)
            trap_o.exc_code = EXC_INSTR_ACCESS_FAULT;
        else if (faults_i.illegal_instr || csr_illegal_i)
            trap_o.exc_code = EXC_ILLEGAL_INSTR;
        else if (faults_i.misaligned_fetch)
            trap_o.exc_code = EXC_INSTR_MISALIGNED;
        else if (op_i == ECALL)
            trap_o.exc_code = (priv_i == PRIV_USER) ? EXC_ECALL_U : EXC_ECALL_M;
        else if (op_i == EBREAK)
            trap_o.exc_code = EXC_BREAKPOINT;
        else if (faults_i.load_access_fault && mem_active)
            trap_o.exc_code = EXC_LOAD_ACCESS_FAULT;
        else begin
            // No exception, MRET wins over a pending interrupt
            trap_o.raise   = 1'b0;
            trap_o.mret    = (op_i == MRET);
            trap_o.irq_ack = irq_pending_i && (op_i != NOP) && (op_i != MRET);
        end

        if (trap_o.mret)
            trap_o.target = mepc_i;
        else if (trap_o.raise || trap_o.irq_ack)
            trap_o.target = mtvec_i;
        else
            trap_o.target = target_i;
    end

    assign jump_o       = jump_i;
    assign ctx_switch_o = trap_o.mret || trap_o.raise || trap_o.irq_ack || jump_i;

endmodule

`default_nettype wire

/* verif/tb_execute_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_execute_stage
    import exec_pkg::*;
    import trap_pkg::*;
;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS      = 3000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TESTS + 4) * CLK_PERIOD + 500;

    // All DUT inputs of one instruction
    typedef struct packed {
        logic        stall;
        word_t       pc;
        word_t       a;
        word_t       b;
        word_t       c;
        exec_op_e    op;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic        compressed;
        priv_level_e priv;
        exc_flags_t  faults;
        csr_addr_t   csr_addr;
        word_t       csr_rdata;
        logic        irq;
        word_t       mtvec;
        word_t       mepc;
    } stim_t;

    typedef struct packed {
        logic    rd_en;
        logic    wr_en;
        csr_op_e op;
        word_t   data;
    } csr_req_t;

    typedef struct packed {
        word_t     result;
        logic      we;
        reg_addr_t rd;
        exec_op_e  op;
    } wb_t;

    typedef struct packed {
        mem_req_t  mem;
        csr_req_t  csr;
        logic      jump;
        trap_out_t trap;
        logic      ctx;
        wb_t       wb;
    } expect_t;

    logic        clk;
    logic        reset_n;
    stim_t       stim;
    logic [31:0] lfsr = 32'h8bec_4fb9;
    expect_t     expected;
    wb_t         exp_wb;
    logic        exp_bubble;
    int          edges = 0;

    word_t       result_o;
    logic        we_o;
    reg_addr_t   rd_o;
    exec_op_e    op_o;
    mem_req_t    mem_req_o;
    logic        csr_read_en_o;
    logic        csr_write_en_o;
    csr_op_e     csr_op_o;
    word_t       csr_data_o;
    logic        jump_o;
    trap_out_t   trap_o;
    logic        ctx_switch_o;

    execute_stage uut (
        .clk            (clk),
        .reset_n        (reset_n),
        .stall_i        (stim.stall),
        .pc_i           (stim.pc),
        .op_a_i         (stim.a),
        .op_b_i         (stim.b),
        .op_c_i         (stim.c),
        .op_i           (stim.op),
        .rd_i           (stim.rd),
        .rs1_i          (stim.rs1),
        .compressed_i   (stim.compressed),
        .priv_i         (stim.priv),
        .faults_i       (stim.faults),
        .csr_addr_i     (stim.csr_addr),
        .csr_rdata_i    (stim.csr_rdata),
        .irq_pending_i  (stim.irq),
        .mtvec_i        (stim.mtvec),
        .mepc_i         (stim.mepc),
        .result_o       (result_o),
        .we_o           (we_o),
        .rd_o           (rd_o),
        .op_o           (op_o),
        .mem_req_o      (mem_req_o),
        .csr_read_en_o  (csr_read_en_o),
        .csr_write_en_o (csr_write_en_o),
        .csr_op_o       (csr_op_o),
        .csr_data_o     (csr_data_o),
        .jump_o         (jump_o),
        .trap_o         (trap_o),
        .ctx_switch_o   (ctx_switch_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Random stimulus
    //////////////////////////////////////////////////

    function automatic logic [31:0] galois_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic stim_t next_stim();
        stim_t s;
        s.stall      = (random_bits(3) == 0);
        s.pc         = random_bits(32);
        s.a          = random_bits(32);
        // Equal operands now and then so eq/ge branches get taken
        s.b          = (random_bits(2) == 0) ? s.a : random_bits(32);
        s.c          = random_bits(32);
        s.op         = exec_op_e'(6'(random_bits(6) % 37));
        s.rd         = (random_bits(3) == 0) ? '0 : 5'(random_bits(5));
        s.rs1        = (random_bits(3) == 0) ? '0 : 5'(random_bits(5));
        s.compressed = (random_bits(1) != 0);
        s.priv       = (random_bits(1) != 0) ? PRIV_MACHINE : PRIV_USER;
        s.faults     = (random_bits(2) == 0) ? exc_flags_t'(4'(random_bits(4))) : '0;
        s.csr_addr   = 12'(random_bits(12));
        s.csr_rdata  = random_bits(32);
        s.irq        = (random_bits(2) == 0);
        s.mtvec      = random_bits(32);
        s.mepc       = random_bits(32);
        return s;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic expect_t predict(stim_t s);
        expect_t e;
        word_t   sum;
        word_t   result;
        logic    is_load;
        logic    is_store;
        logic    writes;
        logic    csr_rd;
        logic    csr_wr;
        logic    illegal;
        logic    slt;
        logic    sltu;

        e        = '0;
        sum      = s.a + s.b;
        slt      = $signed(s.a) < $signed(s.b);
        sltu     = s.a < s.b;
        is_load  = s.op inside {LB, LBU, LH, LHU, LW};
        is_store = s.op inside {SB, SH, SW};
        writes   = !(is_store || s.op inside {NOP, BEQ, BNE, BLT, BLTU, BGE, BGEU});

        e.mem.addr    = {sum[31:2], 2'b00};
        e.mem.read_en = is_load;
        case (s.op)
            SB: begin
                e.mem.strobe = 4'b0001 << sum[1:0];
                e.mem.wdata  = {4{s.c[7:0]}};
            end
            SH: begin
                e.mem.strobe = sum[1] ? 4'b1100 : 4'b0011;
                e.mem.wdata  = {2{s.c[15:0]}};
            end
            SW: begin
                e.mem.strobe = 4'b1111;
                e.mem.wdata  = s.c;
            end
            default: ;
        endcase

        case (s.op)
            CSRRW, CSRRWI: e.csr.op = CSR_WRITE;
            CSRRS, CSRRSI: e.csr.op = CSR_SET;
            CSRRC, CSRRCI: e.csr.op = CSR_CLEAR;
            default:       e.csr.op = CSR_NONE;
        endcase
        csr_rd  = (e.csr.op == CSR_WRITE) ? (s.rd != 0) : (e.csr.op != CSR_NONE);
        csr_wr  = (e.csr.op == CSR_WRITE) || (e.csr.op != CSR_NONE && s.rs1 != 0);
        illegal = (csr_wr && s.csr_addr[11:10] == 2'b11)
               || ((csr_rd || csr_wr) && s.csr_addr[9:8] > 2'(s.priv));
        e.csr.rd_en = csr_rd && !illegal;
        e.csr.wr_en = csr_wr && !illegal;
        e.csr.data  = (s.op inside {CSRRWI, CSRRSI, CSRRCI}) ? {27'b0, s.rs1} : s.a;

        case (s.op)
            BEQ:       e.jump = (s.a == s.b);
            BNE:       e.jump = (s.a != s.b);
            BLT:       e.jump = slt;
            BLTU:      e.jump = sltu;
            BGE:       e.jump = !slt;
            BGEU:      e.jump = !sltu;
            JAL, JALR: e.jump = 1'b1;
            default:   e.jump = 1'b0;
        endcase

        // Causes in falling priority
        e.trap.exc_code = EXC_NONE;
        if (s.faults.instr_access_fault)
            e.trap.exc_code = EXC_INSTR_ACCESS_FAULT;
        else if (s.faults.illegal_instr || illegal)
            e.trap.exc_code = EXC_ILLEGAL_INSTR;
        else if (s.faults.misaligned_fetch)
            e.trap.exc_code = EXC_INSTR_MISALIGNED;
        else if (s.op == ECALL)
            e.trap.exc_code = (s.priv == PRIV_USER) ? EXC_ECALL_U : EXC_ECALL_M;
        else if (s.op == EBREAK)
            e.trap.exc_code = EXC_BREAKPOINT;
        else if (s.faults.load_access_fault && (is_load || is_store))
            e.trap.exc_code = EXC_LOAD_ACCESS_FAULT;
        e.trap.raise   = (e.trap.exc_code != EXC_NONE);
        e.trap.mret    = !e.trap.raise && (s.op == MRET);
        e.trap.irq_ack = !e.trap.raise && !e.trap.mret && s.irq && (s.op != NOP);

        if (e.trap.mret)
            e.trap.target = s.mepc;
        else if (e.trap.raise || e.trap.irq_ack)
            e.trap.target = s.mtvec;
        else if (s.op == JALR)
            e.trap.target = {sum[31:1], 1'b0};
        else if (s.op == JAL)
            e.trap.target = sum;
        else
            e.trap.target = s.pc + s.c;
        e.ctx = e.trap.mret || e.trap.raise || e.trap.irq_ack || e.jump;

        case (s.op)
            LUI:       result = s.b;
            SUB:       result = s.a - s.b;
            SLT:       result = 32'(slt);
            SLTU:      result = 32'(sltu);
            XOR:       result = s.a ^ s.b;
            OR:        result = s.a | s.b;
            AND:       result = s.a & s.b;
            SLL:       result = s.a << s.b[4:0];
            SRL:       result = s.a >> s.b[4:0];
            SRA:       result = word_t'($signed(s.a) >>> s.b[4:0]);
            JAL, JALR: result = s.pc + (s.compressed ? 32'd2 : 32'd4);
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: result = s.csr_rdata;
            default:   result = sum;
        endcase

        // Stall leaves the bubble from the clear above
        if (!s.stall) begin
            e.wb.result = result;
            e.wb.we     = writes && (s.rd != 0) && !e.trap.raise;
            e.wb.rd     = s.rd;
            e.wb.op     = s.op;
        end
        return e;
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Compare, stimulus and watchdog
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        expected = predict(stim);
        check("mem_req_o.addr", mem_req_o.addr, expected.mem.addr);
        check("mem_req_o.read_en", 32'(mem_req_o.read_en), 32'(expected.mem.read_en));
        check("mem_req_o.strobe", 32'(mem_req_o.strobe), 32'(expected.mem.strobe));
        if (expected.mem.strobe != 0)
            check("mem_req_o.wdata", mem_req_o.wdata, expected.mem.wdata);
        check("csr_read_en_o", 32'(csr_read_en_o), 32'(expected.csr.rd_en));
        check("csr_write_en_o", 32'(csr_write_en_o), 32'(expected.csr.wr_en));
        check("csr_op_o", 32'(csr_op_o), 32'(expected.csr.op));
        if (expected.csr.op != CSR_NONE)
            check("csr_data_o", csr_data_o, expected.csr.data);
        check("jump_o", 32'(jump_o), 32'(expected.jump));
        check("trap_o.raise", 32'(trap_o.raise), 32'(expected.trap.raise));
        check("trap_o.mret", 32'(trap_o.mret), 32'(expected.trap.mret));
        check("trap_o.irq_ack", 32'(trap_o.irq_ack), 32'(expected.trap.irq_ack));
        check("trap_o.exc_code", 32'(trap_o.exc_code), 32'(expected.trap.exc_code));
        check("ctx_switch_o", 32'(ctx_switch_o), 32'(expected.ctx));
        if (expected.ctx)
            check("trap_o.target", trap_o.target, expected.trap.target);

        // Registered outputs hold what the previous edge latched
        if (edges > 0) begin
            check("we_o", 32'(we_o), 32'(exp_wb.we));
            check("rd_o", 32'(rd_o), 32'(exp_wb.rd));
            check("op_o", 32'(op_o), 32'(exp_wb.op));
            if (exp_wb.we || exp_bubble)
                check("result_o", result_o, exp_wb.result);
        end
        exp_bubble = !reset_n || stim.stall;
        exp_wb     = reset_n ? expected.wb : '0;
        edges++;
    end

    initial begin
        clk     = 1'b0;
        reset_n = 1'b0;
        stim    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int n = 0; n < N_TESTS; n++) begin
            stim = next_stim();
            @(negedge clk);
        end
        stim = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
